// File: common/dcache_port_if.sv
//##########################################################
// Data memory port
// Load and store strobes, store line and load line
//##########################################################

`timescale 1ns/100ps
`default_nettype none

interface dcache_port_if;

	// Single-cycle strobes, never both high
	logic load;
	logic store;

	vpu_pkg::line_addr_t line_addr;
	vpu_pkg::line_t store_data;
	vpu_pkg::byte_mask_t store_mask;

	// Line read by the last load
	vpu_pkg::line_t load_data;

	modport stage
	(
		output load,
		output store,
		output line_addr,
		output store_data,
		output store_mask,
		input load_data
	);

	modport memory
	(
		input load,
		input store,
		input line_addr,
		input store_data,
		input store_mask,
		output load_data
	);

endinterface

`default_nettype wire

// File: common/vpu_config.svh
//##########################################################
// Vector core configuration
// Lane count, cache line size and data memory depth
//##########################################################

`ifndef VPU_CONFIG_SVH
`define VPU_CONFIG_SVH

// Number of 32-bit lanes in a vector register
`define VECTOR_LANES 4

// One vector fills exactly one cache line
`define CACHE_LINE_WORDS (`VECTOR_LANES)
`define CACHE_LINE_BYTES (`VECTOR_LANES * 4)

// Depth of the line-wide data memory
`define MEM_LINES 16

`endif

// File: common/vpu_pkg.sv
//##########################################################
// Vector core shared types
// Addresses, cache lines, masks and memory operations
//##########################################################

`default_nettype none

`include "vpu_config.svh"

package vpu_pkg;

	// Byte address
	typedef logic [31:0] addr_t;

	// Line index, the address without the byte offset within a line
	typedef logic [31 - $clog2(`CACHE_LINE_BYTES):0] line_addr_t;

	// Line data, byte 0 in the most significant bits
	typedef logic [`CACHE_LINE_BYTES * 8 - 1:0] line_t;

	// Store byte enables, bit 15 is line byte 0
	typedef logic [`CACHE_LINE_BYTES - 1:0] byte_mask_t;

	// Lane enables, the top bit is lane 0
	typedef logic [`VECTOR_LANES - 1:0] lane_mask_t;

	// Lane number
	typedef logic [$clog2(`VECTOR_LANES) - 1:0] lane_idx_t;

	// Memory access type
	typedef enum logic [1:0]
	{
		MEM_B     = 2'd0,
		MEM_S     = 2'd1,
		MEM_L     = 2'd2,
		MEM_BLOCK = 2'd3
	} mem_op_t;

endpackage

`default_nettype wire

// File: mem_stage/mem_access_stage.sv
//##########################################################
// Memory access pipeline stage
// Checks alignment, issues line loads and stores to the
// data memory and registers the writeback outputs
//##########################################################

`timescale 1ns/100ps
`default_nettype none

`include "vpu_config.svh"

module mem_access_stage
(
	input logic clk,
	input logic reset,

	// From execute stage
	input logic ex_valid,
	input vpu_pkg::mem_op_t ex_op,
	input logic ex_is_load,
	input vpu_pkg::addr_t ex_addr,
	input vpu_pkg::line_t ex_store_value,
	input vpu_pkg::lane_mask_t ex_mask,
	input vpu_pkg::lane_idx_t ex_lane,
	input logic squash,

	// To data memory
	dcache_port_if.stage dport,

	// To writeback stage
	output logic ma_valid,
	output logic ma_was_load,
	output logic ma_alignment_fault,
	output vpu_pkg::lane_idx_t ma_lane
);

	localparam int OFFSET_BITS = $clog2(`CACHE_LINE_BYTES);

	logic misaligned;
	logic lane_active;
	logic issue;
	logic fault_nxt;

	// Alignment follows the access size
	always_comb
	begin
		case (ex_op)
			vpu_pkg::MEM_B:
				misaligned = 1'b0;
			vpu_pkg::MEM_S:
				misaligned = ex_addr[0] != 1'b0;
			vpu_pkg::MEM_L:
				misaligned = ex_addr[1:0] != 2'b00;
			default:
				misaligned = ex_addr[OFFSET_BITS - 1:0] != '0;
		endcase
	end

	// Lane 0 is the top bit of the mask
	assign lane_active = (ex_op == vpu_pkg::MEM_BLOCK)
		? (ex_mask != '0)
		: ex_mask[`VECTOR_LANES - 1 - ex_lane];

	assign issue = ex_valid && !squash && !misaligned && lane_active;
	assign fault_nxt = ex_valid && !squash && misaligned;

	assign dport.load = issue && ex_is_load;
	assign dport.store = issue && !ex_is_load;
	assign dport.line_addr = ex_addr[31:OFFSET_BITS];

	store_line_formatter formatter_i
	(
		.op(ex_op),
		.byte_offset(ex_addr[3:0]),
		.store_value(ex_store_value),
		.lane_mask(ex_mask),
		.line_data(dport.store_data),
		.store_mask(dport.store_mask)
	);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ma_valid <= 1'b0;
			ma_was_load <= 1'b0;
			ma_alignment_fault <= 1'b0;
		end
		else
		begin
			ma_valid <= ex_valid && !squash;
			ma_was_load <= dport.load;
			ma_alignment_fault <= fault_nxt;
		end
	end

	// Word of the line that holds a scalar
	always_ff @(posedge clk)
	begin
		ma_lane <= vpu_pkg::lane_idx_t'(ex_addr[OFFSET_BITS - 1:2]);
	end

	// The formatter must enable at least one byte for any issued store
	a_store_has_bytes: assert property (
		@(posedge clk) disable iff (reset)
		dport.store |-> (dport.store_mask != '0)
	);

endmodule

`default_nettype wire

// File: mem_stage/store_line_formatter.sv
//##########################################################
// Store line formatter
// Places store data in big-endian order within a line
// and builds the byte store mask
//##########################################################

`timescale 1ns/100ps
`default_nettype none

`include "vpu_config.svh"

module store_line_formatter
(
	input vpu_pkg::mem_op_t op,
	input logic [3:0] byte_offset,
	input vpu_pkg::line_t store_value,
	input vpu_pkg::lane_mask_t lane_mask,
	output vpu_pkg::line_t line_data,
	output vpu_pkg::byte_mask_t store_mask
);

	localparam int WORDS = `CACHE_LINE_WORDS;

	logic [31:0] scalar_word;
	logic [3:0] byte_sel;
	vpu_pkg::lane_mask_t word_sel;
	vpu_pkg::line_t vector_line;

	function automatic logic [31:0] swap_bytes(input logic [31:0] value);
		swap_bytes = {value[7:0], value[15:8], value[23:16], value[31:24]};
	endfunction

	// Scalar word and the bytes it covers, byte 0 is the top bit
	always_comb
	begin
		case (op)
			vpu_pkg::MEM_B:
			begin
				scalar_word = {store_value[7:0], 24'd0} >> (8 * byte_offset[1:0]);
				byte_sel = 4'b1000 >> byte_offset[1:0];
			end
			vpu_pkg::MEM_S:
			begin
				scalar_word = {store_value[7:0], store_value[15:8], 16'd0}
					>> (16 * byte_offset[1]);
				byte_sel = byte_offset[1] ? 4'b0011 : 4'b1100;
			end
			default:
			begin
				scalar_word = swap_bytes(store_value[31:0]);
				byte_sel = 4'b1111;
			end
		endcase
	end

	// Each vector word is swapped on its own
	genvar w;
	generate
		for (w = 0; w < WORDS; w++)
		begin : gen_swap
			assign vector_line[w * 32 +: 32] = swap_bytes(store_value[w * 32 +: 32]);
		end
	endgenerate

	// Scalars hit one word, lane 0 is the highest word
	assign word_sel = (op == vpu_pkg::MEM_BLOCK)
		? lane_mask
		: vpu_pkg::lane_mask_t'(1 << (WORDS - 1 - byte_offset[3:2]));

	assign line_data = (op == vpu_pkg::MEM_BLOCK) ? vector_line : {WORDS{scalar_word}};

	genvar b;
	generate
		for (b = 0; b < `CACHE_LINE_BYTES; b++)
		begin : gen_mask
			assign store_mask[b] = word_sel[b / 4] & byte_sel[b % 4];
		end
	endgenerate

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/vpu_pkg.sv
common/dcache_port_if.sv
mem_stage/store_line_formatter.sv
mem_stage/mem_access_stage.sv
verilog/line_memory.sv
verilog/mem_subsystem_top.sv
tests/tb_mem_subsystem.sv

// File: tests/tb_mem_subsystem.sv
//##########################################################
// Memory subsystem testbench
// Random loads and stores checked against a byte model
//##########################################################

`timescale 1ns/100ps
`default_nettype none

`include "vpu_config.svh"

module tb_mem_subsystem;

	localparam int RESET_CYCLES = 8;
	localparam int FILL_CYCLES = `MEM_LINES;
	localparam int TEST_CYCLES = 600;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2 + RESET_CYCLES;
	localparam int MODEL_BYTES = `CACHE_LINE_BYTES * `MEM_LINES;

	logic clk;
	logic reset;
	logic ex_valid;
	vpu_pkg::mem_op_t ex_op;
	logic ex_is_load;
	vpu_pkg::addr_t ex_addr;
	vpu_pkg::line_t ex_store_value;
	vpu_pkg::lane_mask_t ex_mask;
	vpu_pkg::lane_idx_t ex_lane;
	logic squash;

	logic ma_valid;
	logic ma_was_load;
	logic ma_alignment_fault;
	vpu_pkg::lane_idx_t ma_lane;
	vpu_pkg::line_t ma_load_line;

	// Reference memory, byte 0 of a line at the lowest address
	logic [7:0] model_mem [MODEL_BYTES];

	// Results expected after the next rising edge
	logic exp_valid;
	logic exp_was_load;
	logic exp_fault;
	vpu_pkg::lane_idx_t exp_lane;
	vpu_pkg::line_t exp_line;

	logic [31:0] lfsr_state = 32'd26;
	int cycle_count = 0;
	int line_errors = 0;
	int flag_errors = 0;
	int lane_errors = 0;

	mem_subsystem_top dut_i
	(
		.clk(clk),
		.reset(reset),
		.ex_valid(ex_valid),
		.ex_op(ex_op),
		.ex_is_load(ex_is_load),
		.ex_addr(ex_addr),
		.ex_store_value(ex_store_value),
		.ex_mask(ex_mask),
		.ex_lane(ex_lane),
		.squash(squash),
		.ma_valid(ma_valid),
		.ma_was_load(ma_was_load),
		.ma_alignment_fault(ma_alignment_fault),
		.ma_lane(ma_lane),
		.ma_load_line(ma_load_line)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Verification failed");
			$finish;
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_line(input string name, input vpu_pkg::line_t exp,
		input vpu_pkg::line_t act);
		if (act !== exp)
		begin
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
			line_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
			flag_errors++;
		end
	endtask

	task automatic check_lane(input string name, input vpu_pkg::lane_idx_t exp,
		input vpu_pkg::lane_idx_t act);
		if (act !== exp)
		begin
			$display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
			lane_errors++;
		end
	endtask

	function automatic vpu_pkg::line_t model_line(input logic [3:0] line);
		vpu_pkg::line_t l;
		for (int j = 0; j < `CACHE_LINE_BYTES; j++)
			l[(`CACHE_LINE_BYTES - 1 - j) * 8 +: 8] = model_mem[int'(line) * 16 + j];
		return l;
	endfunction

	// Scalar byte k goes to address + k; lane L is store_value word 3 - L
	task automatic model_store(input vpu_pkg::mem_op_t op, input vpu_pkg::addr_t addr,
		input vpu_pkg::line_t value, input vpu_pkg::lane_mask_t mask);
		int base;
		int size;
		base = int'(addr[7:4]) * 16;
		size = (op == vpu_pkg::MEM_B) ? 1 : (op == vpu_pkg::MEM_S) ? 2 : 4;
		if (op == vpu_pkg::MEM_BLOCK)
		begin
			for (int lane = 0; lane < `VECTOR_LANES; lane++)
				if (mask[`VECTOR_LANES - 1 - lane])
					for (int k = 0; k < 4; k++)
						model_mem[base + lane * 4 + k] = value[(3 - lane) * 32 + k * 8 +: 8];
		end
		else
		begin
			for (int k = 0; k < size; k++)
				model_mem[int'(addr[7:0]) + k] = value[k * 8 +: 8];
		end
	endtask

	task automatic check_outputs();
		check_flag("ma_valid", exp_valid, ma_valid);
		check_flag("ma_was_load", exp_was_load, ma_was_load);
		check_flag("ma_alignment_fault", exp_fault, ma_alignment_fault);
		if (exp_valid)
			check_lane("ma_lane", exp_lane, ma_lane);
		check_line("ma_load_line", exp_line, ma_load_line);
	endtask

	task automatic apply_instr(input logic valid, input vpu_pkg::mem_op_t op,
		input logic is_load, input vpu_pkg::addr_t addr, input vpu_pkg::line_t value,
		input vpu_pkg::lane_mask_t mask, input vpu_pkg::lane_idx_t lane, input logic sq);
		logic misaligned;
		logic active;
		logic issue;
		ex_valid = valid;
		ex_op = op;
		ex_is_load = is_load;
		ex_addr = addr;
		ex_store_value = value;
		ex_mask = mask;
		ex_lane = lane;
		squash = sq;
		case (op)
			vpu_pkg::MEM_B: misaligned = 1'b0;
			vpu_pkg::MEM_S: misaligned = addr[0];
			vpu_pkg::MEM_L: misaligned = addr[1:0] != 2'b00;
			default: misaligned = addr[3:0] != 4'd0;
		endcase
		active = (op == vpu_pkg::MEM_BLOCK) ? (mask != '0) : mask[3 - lane];
		issue = valid && !sq && !misaligned && active;
		exp_valid = valid && !sq;
		exp_fault = valid && !sq && misaligned;
		exp_was_load = issue && is_load;
		exp_lane = addr[3:2];
		if (issue && is_load)
			exp_line = model_line(addr[7:4]);
		if (issue && !is_load)
			model_store(op, addr, value, mask);
	endtask

	task automatic drive_random();
		logic [31:0] r;
		logic valid;
		logic sq;
		logic is_load;
		logic misalign;
		logic [3:0] line;
		logic [3:0] offset;
		vpu_pkg::mem_op_t op;
		vpu_pkg::line_t value;
		vpu_pkg::lane_mask_t mask;
		vpu_pkg::lane_idx_t lane;
		draw_bits(3, r);
		valid = r[2:0] != 3'd0;
		draw_bits(3, r);
		sq = r[2:0] == 3'd0;
		draw_bits(2, r);
		op = vpu_pkg::mem_op_t'(r[1:0]);
		draw_bits(1, r);
		is_load = r[0];
		draw_bits(4, r);
		line = r[3:0];
		draw_bits(4, r);
		offset = r[3:0];
		draw_bits(3, r);
		misalign = r[2:0] == 3'd0;
		// Bytes never fault, the rest are forced aligned or misaligned
		case (op)
			vpu_pkg::MEM_S: offset[0] = misalign;
			vpu_pkg::MEM_L: offset[1:0] = misalign ? (offset[1:0] | 2'b01) : 2'b00;
			vpu_pkg::MEM_BLOCK: offset = misalign ? (offset | 4'b0001) : 4'd0;
			default: ;
		endcase
		for (int w = 0; w < `CACHE_LINE_WORDS; w++)
		begin
			draw_bits(32, r);
			value[w * 32 +: 32] = r;
		end
		draw_bits(2, r);
		lane = r[1:0];
		draw_bits(4, r);
		mask = r[3:0];
		// Mostly keep the scalar lane active
		draw_bits(3, r);
		if (op != vpu_pkg::MEM_BLOCK && r[2:0] != 3'd0)
			mask[3 - lane] = 1'b1;
		apply_instr(valid, op, is_load, {24'd0, line, offset}, value, mask, lane, sq);
	endtask

	initial
	begin
		logic [31:0] r;
		vpu_pkg::line_t value;
		reset = 1'b1;
		ex_valid = 1'b0;
		ex_op = vpu_pkg::MEM_B;
		ex_is_load = 1'b0;
		ex_addr = '0;
		ex_store_value = '0;
		ex_mask = '0;
		ex_lane = '0;
		squash = 1'b0;
		exp_valid = 1'b0;
		exp_was_load = 1'b0;
		exp_fault = 1'b0;
		exp_lane = '0;
		exp_line = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_outputs();

		// Fill every line with full block stores so loads never see X
		for (int n = 0; n < FILL_CYCLES; n++)
		begin
			@(negedge clk);
			check_outputs();
			for (int w = 0; w < `CACHE_LINE_WORDS; w++)
			begin
				draw_bits(32, r);
				value[w * 32 +: 32] = r;
			end
			apply_instr(1'b1, vpu_pkg::MEM_BLOCK, 1'b0, vpu_pkg::addr_t'(n * 16), value,
				4'b1111, '0, 1'b0);
		end

		for (int n = FILL_CYCLES; n < TEST_CYCLES; n++)
		begin
			@(negedge clk);
			check_outputs();
			drive_random();
		end
		@(negedge clk);
		check_outputs();

		$display("Errors: line %0d, flag %0d, lane %0d", line_errors, flag_errors,
			lane_errors);
		if (line_errors + flag_errors + lane_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/line_memory.sv
//##########################################################
// Line-wide data memory
// Byte-masked line writes and registered line reads
//##########################################################

`timescale 1ns/100ps
`default_nettype none

`include "vpu_config.svh"

module line_memory
(
	input logic clk,
	input logic reset,
	dcache_port_if.memory dport
);

	localparam int IDX_BITS = $clog2(`MEM_LINES);

	vpu_pkg::line_t mem [`MEM_LINES];
	logic [IDX_BITS - 1:0] line_idx;

	// Only the low line address bits select a line
	assign line_idx = dport.line_addr[IDX_BITS - 1:0];

	always_ff @(posedge clk)
	begin
		if (dport.store)
		begin
			for (int i = 0; i < `CACHE_LINE_BYTES; i++)
			begin
				if (dport.store_mask[i])
					mem[line_idx][i * 8 +: 8] <= dport.store_data[i * 8 +: 8];
			end
		end
	end

	// Read line held until the next load
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			dport.load_data <= '0;
		else if (dport.load)
			dport.load_data <= mem[line_idx];
	end

	a_line_in_range: assert property (
		@(posedge clk) disable iff (reset)
		(dport.load || dport.store) |-> (dport.line_addr < `MEM_LINES)
	);

endmodule

`default_nettype wire

// File: verilog/mem_subsystem_top.sv
//##########################################################
// Memory subsystem top level
// Memory access stage driving the line data memory
//##########################################################

`timescale 1ns/100ps
`default_nettype none

module mem_subsystem_top
(
	input logic clk,
	input logic reset,

	input logic ex_valid,
	input vpu_pkg::mem_op_t ex_op,
	input logic ex_is_load,
	input vpu_pkg::addr_t ex_addr,
	input vpu_pkg::line_t ex_store_value,
	input vpu_pkg::lane_mask_t ex_mask,
	input vpu_pkg::lane_idx_t ex_lane,
	input logic squash,

	output logic ma_valid,
	output logic ma_was_load,
	output logic ma_alignment_fault,
	output vpu_pkg::lane_idx_t ma_lane,
	output vpu_pkg::line_t ma_load_line
);

	dcache_port_if port_if ();

	mem_access_stage stage_i
	(
		.clk(clk),
		.reset(reset),
		.ex_valid(ex_valid),
		.ex_op(ex_op),
		.ex_is_load(ex_is_load),
		.ex_addr(ex_addr),
		.ex_store_value(ex_store_value),
		.ex_mask(ex_mask),
		.ex_lane(ex_lane),
		.squash(squash),
		.dport(port_if.stage),
		.ma_valid(ma_valid),
		.ma_was_load(ma_was_load),
		.ma_alignment_fault(ma_alignment_fault),
		.ma_lane(ma_lane)
	);

	line_memory memory_i
	(
		.clk(clk),
		.reset(reset),
		.dport(port_if.memory)
	);

	// Load line arrives with the registered stage outputs
	assign ma_load_line = port_if.load_data;

endmodule

`default_nettype wire
